// File: common/soc_pkg.sv
`default_nettype none

package soc_pkg;

    // bus widths
    localparam int ADDR_W = 64;
    localparam int DATA_W = 64;

    // load/store size, same codes the core puts on bus_ls_type
    // stores only use the first four
    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        ld  = 3'b011,
        lbu = 3'b100,
        lhu = 3'b101,
        lwu = 3'b110
    } ls_type_e;

    // data ram window, depth comes from RAM_WORDS
    localparam logic [ADDR_W-1:0] RAM_BASE = 64'h0000_0000_8000_0000;

    // interrupt controller map
    // priority of id n sits at base + 4*n
    localparam logic [ADDR_W-1:0] PLIC_BASE      = 64'h0000_0000_0c00_0000;
    localparam logic [ADDR_W-1:0] PLIC_PENDING   = PLIC_BASE + 64'h0000_1000;
    localparam logic [ADDR_W-1:0] PLIC_ENABLE    = PLIC_BASE + 64'h0000_2000;
    localparam logic [ADDR_W-1:0] PLIC_THRESHOLD = PLIC_BASE + 64'h0020_0000;
    localparam logic [ADDR_W-1:0] PLIC_CLAIM     = PLIC_BASE + 64'h0020_0004;

    // step from context 0 to context 1
    localparam logic [ADDR_W-1:0] PLIC_CTX_STRIDE_EN = 64'h0000_0080;
    localparam logic [ADDR_W-1:0] PLIC_CTX_STRIDE_TH = 64'h0000_1000;

    // sources are ids 1..NUM_SRC, id 0 is no interrupt
    localparam int NUM_SRC = 5;
    localparam int PRIO_W  = 3;

    // one latched request towards a target
    // strobe is high for a single cycle, the rest stays put until done
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        ls_type_e          ls;
        logic              write;
        logic              strobe;
    } bus_req_t;

    // answer from one target
    // rdata only matters in the ack cycle
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              ack;
    } slave_rsp_t;

endpackage

`default_nettype wire

// File: hw/bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module bus_port #(
    parameter int RAM_WORDS = 2048
) (
    input  wire                             CLOCK_50,
    input  wire                             KEY0,
    input  wire  [soc_pkg::ADDR_W-1:0]      bus_address,
    input  wire  [soc_pkg::DATA_W-1:0]      bus_write_data,
    input  soc_pkg::ls_type_e               bus_ls_type,
    input  wire                             bus_read_enable,
    input  wire                             bus_write_enable,
    output logic [soc_pkg::DATA_W-1:0]      bus_read_data,
    output logic                            bus_read_done,
    output logic                            bus_write_done,
    output soc_pkg::bus_req_t               ram_req,
    output soc_pkg::bus_req_t               plic_req,
    input  soc_pkg::slave_rsp_t             ram_rsp,
    input  soc_pkg::slave_rsp_t             plic_rsp
);

    // address windows
    localparam logic [soc_pkg::ADDR_W-1:0] RAM_END =
        soc_pkg::RAM_BASE + soc_pkg::ADDR_W'(RAM_WORDS) * 4;
    localparam logic [soc_pkg::ADDR_W-1:0] PLIC_END =
        soc_pkg::PLIC_CLAIM + soc_pkg::PLIC_CTX_STRIDE_TH + 4;

    // request as seen at the enable edge
    // .strobe doubles as "decode next cycle"
    soc_pkg::bus_req_t cur_q;

    logic ram_hit;
    logic plic_hit;

    // one-cycle strobes, one per target
    logic ram_stb;
    logic plic_stb;
    // unmapped access acks itself
    logic unm_stb;

    logic                       ack;
    logic [soc_pkg::DATA_W-1:0] ack_rdata;

    // decode from the latched address
    assign ram_hit  = (cur_q.addr >= soc_pkg::RAM_BASE) && (cur_q.addr < RAM_END);
    assign plic_hit = (cur_q.addr >= soc_pkg::PLIC_BASE) && (cur_q.addr < PLIC_END);

    // stage 1: capture the pulse and the payload with it
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            cur_q <= '0;
        end else begin
            cur_q.strobe <= bus_read_enable || bus_write_enable;
            if (bus_read_enable || bus_write_enable) begin
                cur_q.addr  <= bus_address;
                cur_q.wdata <= bus_write_data;
                cur_q.ls    <= bus_ls_type;
                cur_q.write <= bus_write_enable;
            end
        end
    end

    // stage 2: strobe exactly one target, drop the matching done
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            ram_stb        <= 1'b0;
            plic_stb       <= 1'b0;
            unm_stb        <= 1'b0;
            bus_read_done  <= 1'b1;
            bus_write_done <= 1'b1;
        end else begin
            ram_stb  <= cur_q.strobe && ram_hit;
            plic_stb <= cur_q.strobe && !ram_hit && plic_hit;
            unm_stb  <= cur_q.strobe && !ram_hit && !plic_hit;
            if (cur_q.strobe) begin
                if (cur_q.write) begin
                    bus_write_done <= 1'b0;
                end else begin
                    bus_read_done <= 1'b0;
                end
            end
            // done comes back on the ack edge
            if (ack) begin
                if (cur_q.write) begin
                    bus_write_done <= 1'b1;
                end else begin
                    bus_read_done <= 1'b1;
                end
            end
        end
    end

    // only one target can answer at a time
    assign ack = ram_rsp.ack || plic_rsp.ack || unm_stb;

    always_comb begin
        if (ram_rsp.ack) begin
            ack_rdata = ram_rsp.rdata;
        end else if (plic_rsp.ack) begin
            ack_rdata = plic_rsp.rdata;
        end else begin
            // unmapped reads as zero
            ack_rdata = '0;
        end
    end

    // read data holds until the next read finishes
    always_ff @(posedge CLOCK_50) begin
        if (ack && !cur_q.write) begin
            bus_read_data <= ack_rdata;
        end
    end

    // same payload to both, strobe only where decoded
    always_comb begin
        ram_req         = cur_q;
        ram_req.strobe  = ram_stb;
        plic_req        = cur_q;
        plic_req.strobe = plic_stb;
    end

endmodule

`default_nettype wire

// File: ram/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 2048
) (
    input  wire                  CLOCK_50,
    input  wire                  KEY0,
    input  soc_pkg::bus_req_t    req,
    output soc_pkg::slave_rsp_t  rsp
);

    localparam int AW = $clog2(RAM_WORDS);
    localparam int DW = soc_pkg::DATA_W;

    // 32-bit words with byte 0 in bits 7:0
    logic [31:0] mem [RAM_WORDS];

    logic [soc_pkg::ADDR_W-1:0] off;
    logic [AW-1:0]              idx;
    logic [AW-1:0]              idx_hi;
    logic                       is_d;

    // second half of ld/sd runs one cycle later
    logic        hi_q;
    // low word of an ld held for the ack cycle
    logic [31:0] lo_q;

    // single write port
    logic          wr_en;
    logic [AW-1:0] wr_idx;
    logic [3:0]    wr_be;
    logic [31:0]   wr_word;

    logic [31:0]   word;
    logic [31:0]   lane;

    assign off    = req.addr - soc_pkg::RAM_BASE;
    assign idx    = off[AW+1:2];
    assign idx_hi = idx + AW'(1);
    assign is_d   = (req.ls == soc_pkg::ld);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            hi_q <= 1'b0;
        end else begin
            hi_q <= req.strobe && is_d;
        end
    end

    // byte lanes for the current store
    always_comb begin
        wr_en   = 1'b0;
        wr_idx  = idx;
        wr_be   = 4'b0000;
        wr_word = req.wdata[31:0];
        if (hi_q) begin
            // upper word of sd into the next location
            wr_en   = req.write;
            wr_idx  = idx_hi;
            wr_be   = 4'b1111;
            wr_word = req.wdata[63:32];
        end else if (req.strobe && req.write) begin
            wr_en = 1'b1;
            case (req.ls)
                soc_pkg::lb: begin
                    wr_be   = 4'b0001 << off[1:0];
                    wr_word = {4{req.wdata[7:0]}};
                end
                soc_pkg::lh: begin
                    // halves sit on lane 0 or 2
                    wr_be   = 4'b0011 << {off[1], 1'b0};
                    wr_word = {2{req.wdata[15:0]}};
                end
                default: begin
                    // sw and low word of sd
                    wr_be = 4'b1111;
                end
            endcase
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
    end

    // ld captures the low word here and reads the high word in the ack cycle
    always_ff @(posedge CLOCK_50) begin
        if (req.strobe && is_d) begin
            lo_q <= mem[idx];
        end
    end

    // addressed byte/half ends up in the low bits
    assign word = mem[idx];
    assign lane = word >> {off[1:0], 3'b000};

    always_comb begin
        case (req.ls)
            soc_pkg::lb:  rsp.rdata = {{(DW-8){lane[7]}}, lane[7:0]};
            soc_pkg::lbu: rsp.rdata = {{(DW-8){1'b0}}, lane[7:0]};
            soc_pkg::lh:  rsp.rdata = {{(DW-16){lane[15]}}, lane[15:0]};
            soc_pkg::lhu: rsp.rdata = {{(DW-16){1'b0}}, lane[15:0]};
            soc_pkg::lw:  rsp.rdata = {{(DW-32){lane[31]}}, lane};
            soc_pkg::lwu: rsp.rdata = {{(DW-32){1'b0}}, lane};
            soc_pkg::ld:  rsp.rdata = {mem[idx_hi], lo_q};
            default:      rsp.rdata = '0;
        endcase
        // b/h/w ack with the strobe and ld/sd one cycle later
        rsp.ack = (req.strobe && !is_d) || hi_q;
    end

endmodule

`default_nettype wire

// File: plic/plic.sv
`timescale 1ns/1ps
`default_nettype none

module plic (
    input  wire                         CLOCK_50,
    input  wire                         KEY0,
    input  soc_pkg::bus_req_t           req,
    output soc_pkg::slave_rsp_t         rsp,
    input  wire  [soc_pkg::NUM_SRC:1]   irq_src,
    output logic                        meip,
    output logic                        seip
);

    localparam int NS      = soc_pkg::NUM_SRC;
    localparam int PW      = soc_pkg::PRIO_W;
    // context 0 machine, context 1 supervisor
    localparam int NUM_CTX = 2;
    localparam int ID_W    = $clog2(NS + 1);

    logic [PW-1:0] prio [1:NS];
    logic [NS:1]   pending;
    logic [NS:1]   enable [NUM_CTX];
    logic [PW-1:0] threshold [NUM_CTX];

    // result of the claim search per context
    logic [ID_W-1:0] claim_id [NUM_CTX];
    logic [PW-1:0]   best_p [NUM_CTX];

    // register selects
    logic [NS:1]          prio_sel;
    logic                 pend_sel;
    logic [NUM_CTX-1:0]   en_sel;
    logic [NUM_CTX-1:0]   th_sel;
    logic [NUM_CTX-1:0]   cl_sel;

    logic                 rd_stb;
    logic                 wr_stb;
    // pending bits dropped by claim or complete
    logic [NS:1]          clr;
    logic [soc_pkg::DATA_W-1:0] rd_data;

    assign rd_stb = req.strobe && !req.write;
    assign wr_stb = req.strobe && req.write;

    always_comb begin
        for (int i = 1; i <= NS; i++) begin
            prio_sel[i] = (req.addr == soc_pkg::PLIC_BASE + soc_pkg::ADDR_W'(4 * i));
        end
        pend_sel = (req.addr == soc_pkg::PLIC_PENDING);
        for (int c = 0; c < NUM_CTX; c++) begin
            en_sel[c] = (req.addr == soc_pkg::PLIC_ENABLE +
                         soc_pkg::ADDR_W'(c) * soc_pkg::PLIC_CTX_STRIDE_EN);
            th_sel[c] = (req.addr == soc_pkg::PLIC_THRESHOLD +
                         soc_pkg::ADDR_W'(c) * soc_pkg::PLIC_CTX_STRIDE_TH);
            cl_sel[c] = (req.addr == soc_pkg::PLIC_CLAIM +
                         soc_pkg::ADDR_W'(c) * soc_pkg::PLIC_CTX_STRIDE_TH);
        end
    end

    // highest priority above threshold
    // strict compare keeps the lowest id on a tie
    always_comb begin
        for (int c = 0; c < NUM_CTX; c++) begin
            best_p[c]   = threshold[c];
            claim_id[c] = '0;
            for (int i = 1; i <= NS; i++) begin
                if (pending[i] && enable[c][i] && (prio[i] > best_p[c])) begin
                    best_p[c]   = prio[i];
                    claim_id[c] = ID_W'(i);
                end
            end
        end
    end

    // claim read takes the winner, claim write completes the given id
    always_comb begin
        clr = '0;
        for (int c = 0; c < NUM_CTX; c++) begin
            for (int i = 1; i <= NS; i++) begin
                if (rd_stb && cl_sel[c] && (claim_id[c] == ID_W'(i))) begin
                    clr[i] = 1'b1;
                end
                if (wr_stb && cl_sel[c] && (req.wdata == soc_pkg::DATA_W'(i))) begin
                    clr[i] = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending <= '0;
            for (int i = 1; i <= NS; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < NUM_CTX; c++) begin
                enable[c]    <= '0;
                threshold[c] <= '0;
            end
        end else begin
            // level sources, a clear wins over a set in the same cycle
            pending <= (pending | irq_src) & ~clr;
            if (wr_stb) begin
                for (int i = 1; i <= NS; i++) begin
                    if (prio_sel[i]) begin
                        prio[i] <= req.wdata[PW-1:0];
                    end
                end
                for (int c = 0; c < NUM_CTX; c++) begin
                    if (en_sel[c]) begin
                        enable[c] <= req.wdata[NS:1];
                    end
                    if (th_sel[c]) begin
                        threshold[c] <= req.wdata[PW-1:0];
                    end
                end
            end
        end
    end

    // bitmaps keep id n on bit n, bit 0 reads zero
    always_comb begin
        rd_data = '0;
        for (int i = 1; i <= NS; i++) begin
            if (prio_sel[i]) begin
                rd_data[PW-1:0] = prio[i];
            end
        end
        if (pend_sel) begin
            rd_data[NS:1] = pending;
        end
        for (int c = 0; c < NUM_CTX; c++) begin
            if (en_sel[c]) begin
                rd_data[NS:1] = enable[c];
            end
            if (th_sel[c]) begin
                rd_data[PW-1:0] = threshold[c];
            end
            if (cl_sel[c]) begin
                rd_data[ID_W-1:0] = claim_id[c];
            end
        end
    end

    // answers in the strobe cycle
    always_comb begin
        rsp.rdata = rd_data;
        rsp.ack   = req.strobe;
    end

    assign meip = (claim_id[0] != '0);
    assign seip = (claim_id[1] != '0);

endmodule

`default_nettype wire

// File: hw/soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus #(
    parameter int RAM_WORDS = 2048
) (
    input  wire                             CLOCK_50,
    input  wire                             KEY0,
    input  wire  [soc_pkg::ADDR_W-1:0]      bus_address,
    input  wire  [soc_pkg::DATA_W-1:0]      bus_write_data,
    input  soc_pkg::ls_type_e               bus_ls_type,
    input  wire                             bus_read_enable,
    input  wire                             bus_write_enable,
    input  wire  [soc_pkg::NUM_SRC:1]       irq_src,
    output logic [soc_pkg::DATA_W-1:0]      bus_read_data,
    output logic                            bus_read_done,
    output logic                            bus_write_done,
    output logic                            meip,
    output logic                            seip
);

    // request/answer pairs between the port and its two targets
    soc_pkg::bus_req_t   ram_req;
    soc_pkg::bus_req_t   plic_req;
    soc_pkg::slave_rsp_t ram_rsp;
    soc_pkg::slave_rsp_t plic_rsp;

    // processor side, decode and return path
    bus_port #(
        .RAM_WORDS (RAM_WORDS)
    ) u_bus_port (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .ram_req          (ram_req),
        .plic_req         (plic_req),
        .ram_rsp          (ram_rsp),
        .plic_rsp         (plic_rsp)
    );

    // on-chip data memory
    data_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_data_ram (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (ram_req),
        .rsp      (ram_rsp)
    );

    // interrupt controller, sources straight from the pins
    plic u_plic (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .req      (plic_req),
        .rsp      (plic_rsp),
        .irq_src  (irq_src),
        .meip     (meip),
        .seip     (seip)
    );

endmodule

`default_nettype wire

// File: testbench/soc_bus_chk.sv
`timescale 1ns/1ps
`default_nettype none

module soc_bus_chk #(
    parameter int RAM_WORDS = 2048
) (
    input wire                          CLOCK_50,
    input wire                          KEY0,
    input wire [soc_pkg::ADDR_W-1:0]    bus_address,
    input wire [2:0]                    bus_ls_type,
    input wire                          bus_read_enable,
    input wire                          bus_write_enable,
    input wire                          bus_read_done,
    input wire                          bus_write_done,
    input wire                          meip,
    input wire                          seip,
    input wire [soc_pkg::NUM_SRC:1]     pending,
    input wire [soc_pkg::NUM_SRC:1]     enable0,
    input wire [soc_pkg::NUM_SRC:1]     enable1
);

    // running count of assertion failures
    int   err_cnt;
    logic ram_dbl;

    initial err_cnt = 0;

    // ld/sd into the ram window takes one extra cycle
    assign ram_dbl = (bus_ls_type == soc_pkg::ld) &&
                     (bus_address >= soc_pkg::RAM_BASE) &&
                     (bus_address < soc_pkg::RAM_BASE + 64'(RAM_WORDS) * 64'd4);

    // one request at a time
    one_enable: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(bus_read_enable && bus_write_enable))
    else begin
        $error("read and write enable high in the same cycle");
        err_cnt++;
    end

    // done drops at the edge after the sampling edge
    rd_done_falls: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $past(bus_read_enable, 2) |-> $fell(bus_read_done))
    else begin
        $error("read done did not drop after the read pulse");
        err_cnt++;
    end

    wr_done_falls: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $past(bus_write_enable, 2) |-> $fell(bus_write_done))
    else begin
        $error("write done did not drop after the write pulse");
        err_cnt++;
    end

    // back after 2 cycles, 3 for a ram double
    rd_short: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $past(bus_read_enable && !ram_dbl, 3) |-> $rose(bus_read_done))
    else begin
        $error("read done not back 2 cycles after the pulse");
        err_cnt++;
    end

    rd_long: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $past(bus_read_enable && ram_dbl, 4) |-> $rose(bus_read_done))
    else begin
        $error("ld done not back 3 cycles after the pulse");
        err_cnt++;
    end

    wr_short: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $past(bus_write_enable && !ram_dbl, 3) |-> $rose(bus_write_done))
    else begin
        $error("write done not back 2 cycles after the pulse");
        err_cnt++;
    end

    wr_long: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        $past(bus_write_enable && ram_dbl, 4) |-> $rose(bus_write_done))
    else begin
        $error("sd done not back 3 cycles after the pulse");
        err_cnt++;
    end

    // no enabled pending source, no interrupt line
    meip_idle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ((pending & enable0) == '0) |-> !meip)
    else begin
        $error("meip high with nothing enabled and pending");
        err_cnt++;
    end

    seip_idle: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        ((pending & enable1) == '0) |-> !seip)
    else begin
        $error("seip high with nothing enabled and pending");
        err_cnt++;
    end

endmodule

`default_nettype wire

// File: testbench/tb_soc_bus.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_bus;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    // longest legal access is 3 cycles plus slack
    localparam int DONE_TIMEOUT = 8;
    // rounded-up count of bus accesses over all tests
    localparam int NUM_ACCESSES = 64;
    localparam int NUM_TESTS    = 6;
    localparam int WATCHDOG_NS  = (RESET_CYCLES + NUM_ACCESSES * (DONE_TIMEOUT + 2)
                                   + NUM_TESTS * 4 + 100) * CLK_PERIOD;
    localparam logic [63:0] RAM = soc_pkg::RAM_BASE;

    logic                      CLOCK_50;
    logic                      KEY0;
    logic [63:0]               bus_address;
    logic [63:0]               bus_write_data;
    soc_pkg::ls_type_e         bus_ls_type;
    logic                      bus_read_enable;
    logic                      bus_write_enable;
    logic [soc_pkg::NUM_SRC:1] irq_src;
    logic [63:0]               bus_read_data;
    logic                      bus_read_done;
    logic                      bus_write_done;
    logic                      meip;
    logic                      seip;

    int    seed;
    int    errors;
    int    tests_ok;
    int    tests_bad;
    int    errs_at_start;
    int    last_latency;
    string cur_test;

    soc_bus #(
        .RAM_WORDS (2048)
    ) dut (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .irq_src          (irq_src),
        .bus_read_data    (bus_read_data),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip             (meip),
        .seip             (seip)
    );

    // bus timing and interrupt checks sit inside the dut
    bind soc_bus soc_bus_chk #(
        .RAM_WORDS (RAM_WORDS)
    ) chk (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_ls_type      (bus_ls_type),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .bus_read_done    (bus_read_done),
        .bus_write_done   (bus_write_done),
        .meip             (meip),
        .seip             (seip),
        .pending          (u_plic.pending),
        .enable0          (u_plic.enable[0]),
        .enable1          (u_plic.enable[1])
    );

    initial CLOCK_50 = 1'b0;
    always #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;

    // plic map with id n at base + 4n and contexts by stride
    function automatic logic [63:0] prio_addr(input int id);
        return soc_pkg::PLIC_BASE + 64'(4 * id);
    endfunction

    function automatic logic [63:0] enable_addr(input int ctx);
        return soc_pkg::PLIC_ENABLE + 64'(ctx) * soc_pkg::PLIC_CTX_STRIDE_EN;
    endfunction

    function automatic logic [63:0] thresh_addr(input int ctx);
        return soc_pkg::PLIC_THRESHOLD + 64'(ctx) * soc_pkg::PLIC_CTX_STRIDE_TH;
    endfunction

    function automatic logic [63:0] claim_addr(input int ctx);
        return soc_pkg::PLIC_CLAIM + 64'(ctx) * soc_pkg::PLIC_CTX_STRIDE_TH;
    endfunction

    // keeps the low 'bits' of v and sign or zero fills above
    function automatic logic [63:0] extend(input logic [63:0] v, input int bits,
                                           input logic sgn);
        logic [63:0] mask;
        mask = (bits >= 64) ? '1 : ((64'd1 << bits) - 64'd1);
        extend = v & mask;
        if (sgn && bits < 64 && v[bits-1]) begin
            extend = extend | ~mask;
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // pulse sampled at edge k and done must drop and come back
    task automatic bus_access(input logic wr, input logic [63:0] addr,
                              input logic [63:0] wdata, input soc_pkg::ls_type_e ls,
                              output logic [63:0] rdata);
        int   cycles;
        logic seen_low;
        logic done;
        bus_address      = addr;
        bus_write_data   = wdata;
        bus_ls_type      = ls;
        bus_write_enable = wr;
        bus_read_enable  = !wr;
        @(posedge CLOCK_50);
        #1;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        cycles   = 0;
        seen_low = 1'b0;
        done     = 1'b0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(posedge CLOCK_50);
            #1;
            cycles++;
            if (!(wr ? bus_write_done : bus_read_done)) begin
                seen_low = 1'b1;
            end else if (seen_low) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("[%0t] bus gave no done within %0d cycles for %s at %h",
                     $time, DONE_TIMEOUT, wr ? "write" : "read", addr);
            errors++;
        end
        last_latency = cycles;
        rdata = bus_read_data;
    endtask

    task automatic bus_write(input logic [63:0] addr, input logic [63:0] data,
                             input soc_pkg::ls_type_e ls);
        logic [63:0] unused;
        bus_access(1'b1, addr, data, ls, unused);
    endtask

    task automatic bus_read(input logic [63:0] addr, input soc_pkg::ls_type_e ls,
                            input logic [63:0] exp);
        logic [63:0] got;
        bus_access(1'b0, addr, '0, ls, got);
        check_value($sformatf("bus_read_data (%s %h)", ls.name(), addr), exp, got);
    endtask

    task automatic test_start(input string name);
        cur_test      = name;
        errs_at_start = errors + dut.chk.err_cnt;
    endtask

    task automatic test_finish();
        int n;
        // late latency assertions land within two edges
        repeat (2) @(posedge CLOCK_50);
        #1;
        n = errors + dut.chk.err_cnt - errs_at_start;
        if (n == 0) begin
            tests_ok++;
            $display("[%0t] %s: ok", $time, cur_test);
        end else begin
            tests_bad++;
            $display("[%0t] %s: %0d error(s)", $time, cur_test, n);
        end
    endtask

    task automatic test_reset_unmapped();
        test_start("reset state and unmapped read");
        check_value("bus_read_done", 64'd1, 64'(bus_read_done));
        check_value("bus_write_done", 64'd1, 64'(bus_write_done));
        check_value("meip", 64'd0, 64'(meip));
        check_value("seip", 64'd0, 64'(seip));
        bus_read(64'h0000_0000_4000_0000, soc_pkg::lw, 64'd0);
        assert (last_latency <= 2) else begin
            $display("[%0t] unmapped read took %0d cycles, more than 2", $time, last_latency);
            errors++;
        end
        test_finish();
    endtask

    task automatic test_word_half();
        logic [31:0] w;
        logic [63:0] hd0;
        logic [63:0] hd1;
        test_start("word and half loads");
        w = $random(seed);
        bus_write(RAM, {32'h0, w}, soc_pkg::lw);
        bus_read(RAM, soc_pkg::lw, extend(64'(w), 32, 1'b1));
        bus_read(RAM, soc_pkg::lwu, extend(64'(w), 32, 1'b0));
        // only the low half is stored and the upper data bits are junk
        hd0 = {$random(seed), $random(seed)};
        hd1 = {$random(seed), $random(seed)};
        hd0[15] = 1'b1;
        hd1[15] = 1'b0;
        bus_write(RAM + 64'd4, hd0, soc_pkg::lh);
        bus_write(RAM + 64'd6, hd1, soc_pkg::lh);
        bus_read(RAM + 64'd4, soc_pkg::lh, extend(hd0, 16, 1'b1));
        bus_read(RAM + 64'd4, soc_pkg::lhu, extend(hd0, 16, 1'b0));
        bus_read(RAM + 64'd6, soc_pkg::lh, extend(hd1, 16, 1'b1));
        bus_read(RAM + 64'd6, soc_pkg::lhu, extend(hd1, 16, 1'b0));
        bus_read(RAM + 64'd4, soc_pkg::lw,
                 extend(64'({hd1[15:0], hd0[15:0]}), 32, 1'b1));
        test_finish();
    endtask

    task automatic test_bytes();
        logic [7:0] by [4];
        int b;
        test_start("byte lanes");
        for (b = 0; b < 4; b++) begin
            by[b] = 8'($random(seed));
            // lanes 0 and 2 negative and lanes 1 and 3 positive
            by[b][7] = !b[0];
            bus_write(RAM + 64'(8 + b), 64'(by[b]), soc_pkg::lb);
        end
        for (b = 0; b < 4; b++) begin
            bus_read(RAM + 64'(8 + b), soc_pkg::lb, extend(64'(by[b]), 8, 1'b1));
            bus_read(RAM + 64'(8 + b), soc_pkg::lbu, extend(64'(by[b]), 8, 1'b0));
        end
        bus_read(RAM + 64'd8, soc_pkg::lw,
                 extend(64'({by[3], by[2], by[1], by[0]}), 32, 1'b1));
        test_finish();
    endtask

    task automatic test_double();
        logic [63:0] d;
        test_start("double store and load");
        d = {$random(seed), $random(seed)};
        bus_write(RAM + 64'd16, d, soc_pkg::ld);
        bus_read(RAM + 64'd16, soc_pkg::ld, d);
        // low word first in memory
        bus_read(RAM + 64'd16, soc_pkg::lw, extend(d, 32, 1'b1));
        bus_read(RAM + 64'd20, soc_pkg::lw, extend(d >> 32, 32, 1'b1));
        test_finish();
    endtask

    task automatic test_plic_claim();
        test_start("interrupt registers and claim");
        bus_write(prio_addr(1), 64'd3, soc_pkg::lw);
        bus_write(thresh_addr(0), 64'd1, soc_pkg::lw);
        bus_write(enable_addr(0), 64'h2, soc_pkg::lw);
        bus_write(enable_addr(1), 64'h0, soc_pkg::lw);
        bus_read(prio_addr(1), soc_pkg::lw, 64'd3);
        bus_read(thresh_addr(0), soc_pkg::lw, 64'd1);
        bus_read(enable_addr(0), soc_pkg::lw, 64'h2);
        bus_read(enable_addr(1), soc_pkg::lw, 64'h0);
        // one edge with source 1 high latches pending
        irq_src[1] = 1'b1;
        @(posedge CLOCK_50);
        #1;
        irq_src[1] = 1'b0;
        check_value("meip", 64'd1, 64'(meip));
        check_value("seip", 64'd0, 64'(seip));
        bus_read(claim_addr(0), soc_pkg::lw, 64'd1);
        check_value("meip", 64'd0, 64'(meip));
        test_finish();
    endtask

    task automatic test_plic_priority();
        test_start("claim tie, threshold and complete");
        bus_write(prio_addr(2), 64'd5, soc_pkg::lw);
        bus_write(prio_addr(4), 64'd5, soc_pkg::lw);
        bus_write(enable_addr(0), (64'd1 << 2) | (64'd1 << 4), soc_pkg::lw);
        irq_src[2] = 1'b1;
        irq_src[4] = 1'b1;
        @(posedge CLOCK_50);
        #1;
        irq_src = '0;
        bus_read(soc_pkg::PLIC_PENDING, soc_pkg::lw, (64'd1 << 2) | (64'd1 << 4));
        // lower id wins on equal priority
        bus_read(claim_addr(0), soc_pkg::lw, 64'd2);
        bus_write(thresh_addr(0), 64'd5, soc_pkg::lw);
        bus_read(claim_addr(0), soc_pkg::lw, 64'd0);
        check_value("meip", 64'd0, 64'(meip));
        bus_read(soc_pkg::PLIC_PENDING, soc_pkg::lw, 64'd1 << 4);
        bus_write(claim_addr(0), 64'd4, soc_pkg::lw);
        bus_read(soc_pkg::PLIC_PENDING, soc_pkg::lw, 64'd0);
        test_finish();
    endtask

    initial begin
        KEY0             = 1'b0;
        bus_address      = '0;
        bus_write_data   = '0;
        bus_ls_type      = soc_pkg::lb;
        bus_read_enable  = 1'b0;
        bus_write_enable = 1'b0;
        irq_src          = '0;
        seed             = 32'h2ab3bc8a;
        errors           = 0;
        tests_ok         = 0;
        tests_bad        = 0;
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        #1;
        KEY0 = 1'b1;
        @(posedge CLOCK_50);
        #1;
        test_reset_unmapped();
        test_word_half();
        test_bytes();
        test_double();
        test_plic_claim();
        test_plic_priority();
        $display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
        if (tests_bad == 0 && errors + dut.chk.err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // stuck bus or missing done ends the run here
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: soc_bus.f
common/soc_pkg.sv
hw/bus_port.sv
ram/data_ram.sv
plic/plic.sv
hw/soc_bus.sv
testbench/soc_bus_chk.sv
testbench/tb_soc_bus.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_soc_bus
FILELIST  := soc_bus.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Test passed

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# error limit raised so the run goes on after an assertion fires
run: $(BIN)
	@out="$$(./$(BIN) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
